//--- pbch_macros.svh
`ifndef PBCH_MACROS_SVH
`define PBCH_MACROS_SVH

// one OFDM symbol of the SSB as seen after the FFT
`define PBCH_FFT_LEN 256
`define PBCH_GUARD_SC 8
`define PBCH_PILOTS_PER_SYM 60

// DMRS table size, in bit pairs per ibar_SSB candidate
`define PBCH_DMRS_LEN 144
`define PBCH_NUM_IBAR 8

// length-31 Gold sequence parameters
`define PBCH_GOLD_NC 1600
`define PBCH_LFSR_N 31

// a sample carries the real part in the low half and the imaginary part in the high half
`define PBCH_SAMPLE_DW 32

`endif

//--- pbch_pkg.sv
`default_nettype none

`include "pbch_macros.svh"

package pbch_pkg;

    typedef logic [9:0] cell_id_t;
    typedef logic [2:0] ibar_t;
    typedef logic [1:0] qpsk_bits_t;
    typedef logic [7:0] dmrs_addr_t;

    // one table entry holds pair k of every candidate, candidate i at index i
    typedef qpsk_bits_t [`PBCH_NUM_IBAR-1:0] dmrs_row_t;

    // up to 60 pilots with two bits each
    typedef logic [6:0] corr_t;

    typedef enum logic [2:0] {IDLE, LOAD, SKIP, STORE, DONE} gen_state_e;

    typedef enum logic [1:0] {WAIT, COUNT, DECIDE} det_state_e;

endpackage

`default_nettype wire

//--- pbch_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// DMRS table writes from the Gold generator
interface dmrs_wr_if;
    logic                  wr_valid;
    pbch_pkg::dmrs_addr_t  wr_addr;
    pbch_pkg::dmrs_row_t   wr_row;
    logic                  wr_done;

    modport source (output wr_valid, wr_addr, wr_row, wr_done);
    modport sink   (input  wr_valid, wr_addr, wr_row, wr_done);
endinterface

// demodulated pilots of one PBCH symbol
interface pilot_if;
    logic                  p_valid;
    pbch_pkg::dmrs_addr_t  p_idx;
    pbch_pkg::qpsk_bits_t  p_rx;
    logic                  p_last;

    modport source (output p_valid, p_idx, p_rx, p_last);
    modport sink   (input  p_valid, p_idx, p_rx, p_last);
endinterface

// pilots together with the reference pairs of all candidates
interface ref_if;
    logic                  r_valid;
    pbch_pkg::qpsk_bits_t  r_rx;
    pbch_pkg::dmrs_row_t   r_row;
    logic                  r_last;

    modport source (output r_valid, r_rx, r_row, r_last);
    modport sink   (input  r_valid, r_rx, r_row, r_last);
endinterface

`default_nettype wire

//--- dmrs_gold_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "pbch_macros.svh"

module dmrs_gold_gen (
    input  logic               clk_i,
    input  logic               reset_ni,
    input  pbch_pkg::cell_id_t cell_id_i,
    input  logic               cell_id_valid_i,
    dmrs_wr_if.source          wr,
    output pbch_pkg::cell_id_t cell_id_o
);

    pbch_pkg::gen_state_e      state_q;
    pbch_pkg::cell_id_t        cell_id_q;
    logic [10:0]               cnt_q;
    logic [`PBCH_LFSR_N-1:0]   x1_q;
    logic [`PBCH_LFSR_N-1:0]   x1_nxt;
    logic [`PBCH_LFSR_N-1:0]   x2_q   [`PBCH_NUM_IBAR];
    logic [`PBCH_LFSR_N-1:0]   x2_nxt [`PBCH_NUM_IBAR];
    logic [`PBCH_NUM_IBAR-1:0] chip;
    logic [`PBCH_NUM_IBAR-1:0] hi_q;
    logic                      wr_valid_q;
    logic                      wr_done_q;
    pbch_pkg::dmrs_addr_t      wr_addr_q;
    pbch_pkg::dmrs_row_t       wr_row_q;

    // c_init = 2^11 (i+1) (floor(N_id/4)+1) + 2^6 (i+1) + (N_id mod 4)
    function automatic logic [`PBCH_LFSR_N-1:0] calc_c_init(input pbch_pkg::cell_id_t id,
                                                           input int unsigned idx);
        logic [31:0] v;
        v = (((idx + 1) * ((id >> 2) + 1)) << 11) + ((idx + 1) << 6) + id[1:0];
        return v[`PBCH_LFSR_N-1:0];
    endfunction

    // bit j of a register holds x(n+j), so bit 0 is the chip of step n
    always_comb begin
        x1_nxt = {x1_q[3] ^ x1_q[0], x1_q[`PBCH_LFSR_N-1:1]};
        for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
            x2_nxt[i] = {x2_q[i][3] ^ x2_q[i][2] ^ x2_q[i][1] ^ x2_q[i][0],
                         x2_q[i][`PBCH_LFSR_N-1:1]};
            chip[i]   = x1_q[0] ^ x2_q[i][0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q    <= pbch_pkg::IDLE;
            cell_id_q  <= '0;
            cnt_q      <= '0;
            wr_valid_q <= 1'b0;
            wr_done_q  <= 1'b0;
        end else if (cell_id_valid_i) begin
            // a new cell id always restarts the whole table
            cell_id_q  <= cell_id_i;
            state_q    <= pbch_pkg::LOAD;
            wr_valid_q <= 1'b0;
            wr_done_q  <= 1'b0;
        end else begin
            wr_valid_q <= 1'b0;
            case (state_q)
                pbch_pkg::LOAD: begin
                    x1_q <= `PBCH_LFSR_N'(1);
                    for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
                        x2_q[i] <= calc_c_init(cell_id_q, i);
                    end
                    cnt_q   <= '0;
                    state_q <= pbch_pkg::SKIP;
                end
                pbch_pkg::SKIP: begin
                    x1_q <= x1_nxt;
                    x2_q <= x2_nxt;
                    if (cnt_q == `PBCH_GOLD_NC - 1) begin
                        cnt_q   <= '0;
                        state_q <= pbch_pkg::STORE;
                    end else begin
                        cnt_q <= cnt_q + 11'd1;
                    end
                end
                pbch_pkg::STORE: begin
                    x1_q <= x1_nxt;
                    x2_q <= x2_nxt;
                    cnt_q <= cnt_q + 11'd1;
                    if (!cnt_q[0]) begin
                        hi_q <= chip;
                    end else begin
                        // even chip is the high bit of the pair
                        wr_valid_q <= 1'b1;
                        wr_addr_q  <= cnt_q[8:1];
                        for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
                            wr_row_q[i] <= {hi_q[i], chip[i]};
                        end
                    end
                    if (cnt_q == 2 * `PBCH_DMRS_LEN - 1) begin
                        wr_done_q <= 1'b1;
                        state_q   <= pbch_pkg::DONE;
                    end
                end
                // IDLE and DONE wait for the next cell id
                default: begin
                end
            endcase
        end
    end

    assign wr.wr_valid = wr_valid_q;
    assign wr.wr_addr  = wr_addr_q;
    assign wr.wr_row   = wr_row_q;
    assign wr.wr_done  = wr_done_q;
    assign cell_id_o   = cell_id_q;

    // table writes only ever follow a cycle spent in STORE
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        $rose(wr_valid_q) |-> $past(state_q == pbch_pkg::STORE));

endmodule

`default_nettype wire

//--- dmrs_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "pbch_macros.svh"

module dmrs_store (
    input  logic    clk_i,
    dmrs_wr_if.sink wr,
    pilot_if.sink   p,
    ref_if.source   r
);

    pbch_pkg::dmrs_row_t  mem [`PBCH_DMRS_LEN];
    pbch_pkg::dmrs_row_t  row_q;
    pbch_pkg::qpsk_bits_t rx_q;
    logic                 valid_q;
    logic                 last_q;

    always_ff @(posedge clk_i) begin
        if (wr.wr_valid) begin
            mem[wr.wr_addr] <= wr.wr_row;
        end
    end

    // the pilot fields are delayed by one cycle so they line up with the table read
    always_ff @(posedge clk_i) begin
        row_q   <= mem[p.p_idx];
        rx_q    <= p.p_rx;
        valid_q <= p.p_valid;
        last_q  <= p.p_last;
    end

    assign r.r_valid = valid_q;
    assign r.r_rx    = rx_q;
    assign r.r_row   = row_q;
    assign r.r_last  = last_q;

    // pilots are only read once the generator has finished the table
    assert property (@(posedge clk_i) p.p_valid |-> !wr.wr_valid);

endmodule

`default_nettype wire

//--- pilot_extract.sv
`timescale 1ns/1ps
`default_nettype none

`include "pbch_macros.svh"

module pilot_extract (
    input  logic                       clk_i,
    input  logic                       reset_ni,
    input  logic [`PBCH_SAMPLE_DW-1:0] sample_i,
    input  logic                       sample_valid_i,
    input  logic                       pbch_start_i,
    input  logic                       dmrs_ready_i,
    input  pbch_pkg::cell_id_t         cell_id_i,
    pilot_if.source                    p
);

    pbch_pkg::det_state_e state_q;
    logic [7:0]           sc_q;
    logic [7:0]           sc_off;
    pbch_pkg::dmrs_addr_t pil_cnt_q;
    logic                 is_pilot;
    logic                 p_valid_q;
    pbch_pkg::dmrs_addr_t p_idx_q;
    pbch_pkg::qpsk_bits_t p_rx_q;

    // pilots sit every fourth subcarrier outside the guards, shifted by N_id mod 4
    assign sc_off   = sc_q - 8'(`PBCH_GUARD_SC);
    assign is_pilot = (sc_q >= `PBCH_GUARD_SC) && (sc_q < `PBCH_FFT_LEN - `PBCH_GUARD_SC) &&
                      (sc_off[1:0] == cell_id_i[1:0]);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q   <= pbch_pkg::WAIT;
            sc_q      <= '0;
            pil_cnt_q <= '0;
            p_valid_q <= 1'b0;
        end else begin
            p_valid_q <= 1'b0;
            case (state_q)
                pbch_pkg::WAIT: begin
                    if (pbch_start_i && dmrs_ready_i) begin
                        sc_q      <= '0;
                        pil_cnt_q <= '0;
                        state_q   <= pbch_pkg::COUNT;
                    end
                end
                pbch_pkg::COUNT: begin
                    if (!dmrs_ready_i) begin
                        // the table is being rebuilt, so drop the symbol
                        state_q <= pbch_pkg::WAIT;
                    end else if (sample_valid_i) begin
                        if (is_pilot) begin
                            // hard decision on the sign bits of real and imaginary
                            p_valid_q <= 1'b1;
                            p_idx_q   <= pil_cnt_q;
                            p_rx_q    <= {sample_i[`PBCH_SAMPLE_DW/2-1],
                                          sample_i[`PBCH_SAMPLE_DW-1]};
                            pil_cnt_q <= pil_cnt_q + 8'd1;
                        end
                        sc_q <= sc_q + 8'd1;
                        if (sc_q == `PBCH_FFT_LEN - 1) begin
                            state_q <= pbch_pkg::DECIDE;
                        end
                    end
                end
                default: begin
                    state_q <= pbch_pkg::WAIT;
                end
            endcase
        end
    end

    assign p.p_valid = p_valid_q;
    assign p.p_idx   = p_idx_q;
    assign p.p_rx    = p_rx_q;
    assign p.p_last  = (state_q == pbch_pkg::DECIDE);

    assert property (@(posedge clk_i) disable iff (!reset_ni)
        p.p_last |-> pil_cnt_q == `PBCH_PILOTS_PER_SYM);

endmodule

`default_nettype wire

//--- ibar_correlator.sv
`timescale 1ns/1ps
`default_nettype none

`include "pbch_macros.svh"

module ibar_correlator (
    input  logic              clk_i,
    input  logic              reset_ni,
    ref_if.sink               r,
    output pbch_pkg::ibar_t   ibar_o,
    output pbch_pkg::corr_t   peak_corr_o,
    output logic              ibar_valid_o
);

    pbch_pkg::corr_t acc_q [`PBCH_NUM_IBAR];
    pbch_pkg::corr_t sum   [`PBCH_NUM_IBAR];
    logic [1:0]      agree [`PBCH_NUM_IBAR];
    pbch_pkg::ibar_t best_idx;
    pbch_pkg::corr_t best_val;
    pbch_pkg::ibar_t ibar_q;
    pbch_pkg::corr_t peak_q;
    logic            valid_q;

    // count matching bits against every candidate and fold in the current pilot
    always_comb begin
        for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
            agree[i] = {1'b0, r.r_rx[1] == r.r_row[i][1]} + {1'b0, r.r_rx[0] == r.r_row[i][0]};
            sum[i]   = r.r_valid ? acc_q[i] + {5'b0, agree[i]} : acc_q[i];
        end
    end

    // a strict compare keeps the lowest index when scores tie
    always_comb begin
        best_idx = '0;
        best_val = sum[0];
        for (int i = 1; i < `PBCH_NUM_IBAR; i++) begin
            if (sum[i] > best_val) begin
                best_val = sum[i];
                best_idx = pbch_pkg::ibar_t'(i);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
                acc_q[i] <= '0;
            end
            ibar_q  <= '0;
            peak_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (r.r_last) begin
                ibar_q  <= best_idx;
                peak_q  <= best_val;
                valid_q <= 1'b1;
                for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
                    acc_q[i] <= '0;
                end
            end else begin
                acc_q <= sum;
            end
        end
    end

    assign ibar_o       = ibar_q;
    assign peak_corr_o  = peak_q;
    assign ibar_valid_o = valid_q;

endmodule

`default_nettype wire

//--- pbch_ibar_detect.sv
`timescale 1ns/1ps
`default_nettype none

`include "pbch_macros.svh"

module pbch_ibar_detect (
    input  logic                       clk_i,
    input  logic                       reset_ni,
    input  pbch_pkg::cell_id_t         cell_id_i,
    input  logic                       cell_id_valid_i,
    input  logic [`PBCH_SAMPLE_DW-1:0] sample_i,
    input  logic                       sample_valid_i,
    input  logic                       pbch_start_i,
    output logic                       dmrs_ready_o,
    output pbch_pkg::ibar_t            ibar_o,
    output pbch_pkg::corr_t            peak_corr_o,
    output logic                       ibar_valid_o
);

    pbch_pkg::cell_id_t cell_id;

    dmrs_wr_if wr_bus ();
    pilot_if   pilot_bus ();
    ref_if     ref_bus ();

    dmrs_gold_gen u_gold_gen (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .cell_id_i       (cell_id_i),
        .cell_id_valid_i (cell_id_valid_i),
        .wr              (wr_bus.source),
        .cell_id_o       (cell_id)
    );

    dmrs_store u_store (
        .clk_i (clk_i),
        .wr    (wr_bus.sink),
        .p     (pilot_bus.sink),
        .r     (ref_bus.source)
    );

    pilot_extract u_extract (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .pbch_start_i   (pbch_start_i),
        .dmrs_ready_i   (wr_bus.wr_done),
        .cell_id_i      (cell_id),
        .p              (pilot_bus.source)
    );

    ibar_correlator u_correlator (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .r            (ref_bus.sink),
        .ibar_o       (ibar_o),
        .peak_corr_o  (peak_corr_o),
        .ibar_valid_o (ibar_valid_o)
    );

    assign dmrs_ready_o = wr_bus.wr_done;

endmodule

`default_nettype wire

//--- tb_pbch_ibar.sv
`timescale 1ns/1ps
`default_nettype none

`include "pbch_macros.svh"

module tb_pbch_ibar;

    localparam int GEN_LIMIT       = 2000;
    localparam int QUIET_CYCLES    = 300;
    localparam int WATCHDOG_CYCLES = 5 * GEN_LIMIT + 20 * QUIET_CYCLES;
    localparam int PILOTS          = `PBCH_PILOTS_PER_SYM;
    localparam int CHIPS           = `PBCH_GOLD_NC + 2 * PILOTS;

    logic                       clk_i;
    logic                       reset_ni;
    pbch_pkg::cell_id_t         cell_id_i;
    logic                       cell_id_valid_i;
    logic [`PBCH_SAMPLE_DW-1:0] sample_i;
    logic                       sample_valid_i;
    logic                       pbch_start_i;
    logic                       dmrs_ready_o;
    pbch_pkg::ibar_t            ibar_o;
    pbch_pkg::corr_t            peak_corr_o;
    logic                       ibar_valid_o;

    // reference pairs of the loaded cell id and the pilot pairs of the last symbol sent
    int         cell_id_model;
    logic [1:0] ref_pair [`PBCH_NUM_IBAR][PILOTS];
    logic [1:0] rx_pair  [PILOTS];
    bit         x1 [CHIPS + `PBCH_LFSR_N];
    bit         x2 [CHIPS + `PBCH_LFSR_N];
    int         errors;
    int         errors_at_start;
    int         test_num;
    int         tests_failed;

    pbch_ibar_detect uut (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .cell_id_i       (cell_id_i),
        .cell_id_valid_i (cell_id_valid_i),
        .sample_i        (sample_i),
        .sample_valid_i  (sample_valid_i),
        .pbch_start_i    (pbch_start_i),
        .dmrs_ready_o    (dmrs_ready_o),
        .ibar_o          (ibar_o),
        .peak_corr_o     (peak_corr_o),
        .ibar_valid_o    (ibar_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

    task automatic check_value(input string what, input int got, input int exp);
        assert (got == exp) else begin
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("error at %0t: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic start_test();
        test_num++;
        errors_at_start = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_start) begin
            $display("test %0d %s: passed", test_num, name);
        end else begin
            $display("test %0d %s: FAILED", test_num, name);
            tests_failed++;
        end
    endtask

    // the two m-sequences written as x(n+31) recurrences over plain bit arrays
    task automatic build_reference(input int id);
        int c_init;
        int base;
        for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
            c_init = 2048 * (i + 1) * (id / 4 + 1) + 64 * (i + 1) + id % 4;
            for (int n = 0; n < `PBCH_LFSR_N; n++) begin
                x1[n] = (n == 0);
                x2[n] = c_init[n];
            end
            for (int n = 0; n < CHIPS; n++) begin
                x1[n + 31] = x1[n + 3] ^ x1[n];
                x2[n + 31] = x2[n + 3] ^ x2[n + 2] ^ x2[n + 1] ^ x2[n];
            end
            for (int p = 0; p < PILOTS; p++) begin
                base = `PBCH_GOLD_NC + 2 * p;
                ref_pair[i][p] = {x1[base] ^ x2[base], x1[base + 1] ^ x2[base + 1]};
            end
        end
    endtask

    task automatic load_cell_id(input int id);
        @(negedge clk_i);
        cell_id_i       = 10'(id);
        cell_id_valid_i = 1'b1;
        @(negedge clk_i);
        cell_id_valid_i = 1'b0;
        cell_id_model   = id;
        build_reference(id);
    endtask

    // counting starts at the falling edge right after the cell id strobe
    task automatic wait_ready();
        int cycles;
        cycles = 1;
        while (!dmrs_ready_o && cycles < GEN_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        check_true(dmrs_ready_o, "dmrs_ready_o did not rise within 2000 cycles of the cell id");
    endtask

    task automatic send_symbol(input bit from_ref, input int cand);
        int          pil;
        int          amp;
        logic [31:0] rnd;
        logic [15:0] re;
        logic [15:0] im;
        @(negedge clk_i);
        pbch_start_i = 1'b1;
        @(negedge clk_i);
        pbch_start_i = 1'b0;
        pil = 0;
        for (int s = 0; s < `PBCH_FFT_LEN; s++) begin
            while ($urandom_range(7) == 0) begin
                sample_valid_i = 1'b0;
                @(negedge clk_i);
            end
            rnd = $urandom();
            re  = rnd[15:0];
            im  = rnd[31:16];
            if (s >= `PBCH_GUARD_SC && s < `PBCH_FFT_LEN - `PBCH_GUARD_SC &&
                (s - `PBCH_GUARD_SC) % 4 == cell_id_model % 4) begin
                if (from_ref) begin
                    // the high bit of the pair sets the sign of the real part
                    amp = $urandom_range(32767, 1);
                    re  = ref_pair[cand][pil][1] ? 16'(-amp) : 16'(amp);
                    amp = $urandom_range(32767, 1);
                    im  = ref_pair[cand][pil][0] ? 16'(-amp) : 16'(amp);
                end
                rx_pair[pil] = {re[15], im[15]};
                pil++;
            end
            sample_i       = {im, re};
            sample_valid_i = 1'b1;
            @(negedge clk_i);
        end
        sample_valid_i = 1'b0;
    endtask

    function automatic void expected_decision(output int best_i, output int best_score);
        int score;
        best_i     = 0;
        best_score = -1;
        for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
            score = 0;
            for (int p = 0; p < PILOTS; p++) begin
                score += int'(rx_pair[p][1] == ref_pair[i][p][1]);
                score += int'(rx_pair[p][0] == ref_pair[i][p][0]);
            end
            if (score > best_score) begin
                best_score = score;
                best_i     = i;
            end
        end
    endfunction

    task automatic run_symbol(input bit from_ref, input int cand);
        int              lat;
        int              exp_i;
        int              exp_score;
        pbch_pkg::ibar_t held_ibar;
        send_symbol(from_ref, cand);
        if (from_ref) begin
            exp_i     = cand;
            exp_score = 2 * PILOTS;
        end else begin
            expected_decision(exp_i, exp_score);
        end
        // we are now one falling edge past the last sample
        lat = 1;
        while (!ibar_valid_o && lat < 20) begin
            @(negedge clk_i);
            lat++;
        end
        check_true(ibar_valid_o, "no ibar_valid_o pulse after the end of the symbol");
        check_value("ibar_valid_o latency", lat, 3);
        check_value("ibar_o", int'(ibar_o), exp_i);
        check_value("peak_corr_o", int'(peak_corr_o), exp_score);
        held_ibar = ibar_o;
        @(negedge clk_i);
        check_value("ibar_valid_o one cycle after the pulse", int'(ibar_valid_o), 0);
        check_value("ibar_o after the pulse", int'(ibar_o), int'(held_ibar));
    endtask

    initial begin
        int id;
        int seen;
        void'($urandom(32'hb26573dc));
        errors          = 0;
        errors_at_start = 0;
        test_num        = 0;
        tests_failed    = 0;
        cell_id_model   = 0;
        reset_ni        = 1'b0;
        cell_id_i       = '0;
        cell_id_valid_i = 1'b0;
        sample_i        = '0;
        sample_valid_i  = 1'b0;
        pbch_start_i    = 1'b0;
        repeat (3) @(negedge clk_i);
        reset_ni = 1'b1;

        start_test();
        check_value("dmrs_ready_o after reset", int'(dmrs_ready_o), 0);
        check_value("ibar_valid_o after reset", int'(ibar_valid_o), 0);
        load_cell_id(int'($urandom_range(1007)));
        wait_ready();
        end_test("cell id load and DMRS generation");

        start_test();
        for (int c = 0; c < `PBCH_NUM_IBAR; c++) begin
            run_symbol(1'b1, c);
        end
        end_test("noiseless symbol of every candidate");

        start_test();
        for (int k = 0; k < 10; k++) begin
            run_symbol(1'b0, 0);
        end
        end_test("random symbols against the model");

        // a start during generation has to be ignored
        start_test();
        load_cell_id(int'($urandom_range(1007)));
        check_value("dmrs_ready_o during generation", int'(dmrs_ready_o), 0);
        @(negedge clk_i);
        pbch_start_i = 1'b1;
        @(negedge clk_i);
        pbch_start_i = 1'b0;
        seen = 0;
        for (int c = 0; c < QUIET_CYCLES; c++) begin
            sample_valid_i = (c < `PBCH_FFT_LEN);
            sample_i       = $urandom();
            if (ibar_valid_o) begin
                seen++;
            end
            @(negedge clk_i);
        end
        sample_valid_i = 1'b0;
        check_value("ibar_valid_o pulses after an early start", seen, 0);
        wait_ready();
        end_test("start before the DMRS table is ready");

        start_test();
        do begin
            id = int'($urandom_range(1007));
        end while (id == cell_id_model);
        load_cell_id(id);
        check_value("dmrs_ready_o after a new cell id", int'(dmrs_ready_o), 0);
        wait_ready();
        run_symbol(1'b1, int'($urandom_range(7)));
        end_test("cell id reload");

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 test_num, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- pbch_ibar.f
+incdir+.
pbch_pkg.sv
pbch_ifs.sv
dmrs_gold_gen.sv
dmrs_store.sv
pilot_extract.sv
ibar_correlator.sv
pbch_ibar_detect.sv
tb_pbch_ibar.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_pbch_ibar
FILELIST  := pbch_ibar.f
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Everything OK$$"

clean:
	rm -rf $(OBJ_DIR)
